/* design/coin_timer.sv */
// Timer and coin circuit
`timescale 1ns/1ps

module coin_timer (
	input  logic              clk,
	input  logic              reset,
	input  vic_io_pkg::game_e game_mode,
	input  logic              coin,
	input  logic              p4_read,
	output logic              timer_bit,
	output logic              coin_active,
	output logic              cpu_reset
);
	import vic_io_pkg::*;

	logic [TIMER_W-1:0] timer_count;
	logic coin_last;
	logic coin_inserted;
	logic [COIN_START_W-1:0] coin_start;
	logic [COIN_LATCH_W-1:0] coin_latch;
	logic [COIN_LATCH_W-1:0] latch_max;

	// Free-running timer
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timer_count <= '0;
			timer_bit   <= 1'b1;
		end
		else if (timer_count == TIMER_PERIOD)
		begin
			timer_count <= '0;
			timer_bit   <= ~timer_bit;
		end
		else
			timer_count <= timer_count + 1'b1;
	end

	// Coin start and coin latch
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			coin_last     <= 1'b0;
			coin_inserted <= 1'b0;
			coin_start    <= '0;
			coin_latch    <= '0;
			// Latch length picked up from the profile while in reset
			case (game_mode)
				GAME_PULSAR, GAME_NSUB: latch_max <= COIN_LATCH_SHORT;
				default: latch_max <= {COIN_LATCH_W{1'b1}};
			endcase
		end
		else
		begin
			coin_last <= coin;
			// Count down the CPU reset pulse
			if (coin_start != '0) coin_start <= coin_start - 1'b1;
			// First P4 read after the pulse loads, later ones count down
			if (p4_read)
			begin
				if (coin_inserted && coin_start == '0)
				begin
					coin_latch    <= latch_max;
					coin_inserted <= 1'b0;
				end
				else if (coin_latch != '0)
					coin_latch <= coin_latch - 1'b1;
			end
			// New coin edge, takes priority over the clear above
			if (coin && !coin_last)
			begin
				coin_inserted <= 1'b1;
				coin_start    <= {COIN_START_W{1'b1}};
			end
		end
	end

	assign coin_active = (coin_latch != '0);
	// CPU held in reset by board reset or a running coin pulse
	assign cpu_reset   = reset || (coin_start != '0);

endmodule

/* design/input_ports.sv */
// Input port read data
`timescale 1ns/1ps

module input_ports (
	input  logic                             clk,
	input  logic                             reset,
	input  vic_io_pkg::game_e                game_mode,
	input  logic [vic_io_pkg::PORT_W-1:0]    in_p1,
	input  logic [vic_io_pkg::PORT_W-1:0]    in_p2,
	input  logic [vic_io_pkg::PORT_W-1:0]    in_p3,
	input  logic [vic_io_pkg::PORT_W-1:0]    in_p4,
	input  logic [vic_io_pkg::NUM_PORTS-1:0] rd_sel,
	input  logic                             timer_bit,
	input  logic                             coin_active,
	output logic [vic_io_pkg::PORT_W-1:0]    io_rdata
);
	import vic_io_pkg::*;

	logic [PORT_W-1:0] p3_byte;
	logic [PORT_W-1:0] p4_byte;
	logic [PORT_W-1:0] sel_byte;

	// Sense bit overlay
	// ----------------------------------------
	// P1 and P2 pass straight through in every kept profile
	always_comb
	begin
		p3_byte = in_p3;
		p4_byte = in_p4;
		case (game_mode)
			GAME_SPACEATTACK:
			begin
				p4_byte[0] = timer_bit;
				// Coin latch is active low here
				p4_byte[7] = ~coin_active;
			end
			GAME_CARNIVAL, GAME_PULSAR:
			begin
				p3_byte[3] = timer_bit;
				p4_byte[3] = coin_active;
			end
			GAME_NSUB: p4_byte[7] = ~coin_active;
			default: p4_byte = in_p4;
		endcase
	end

	// Port mux, rd_sel is one-hot or zero
	always_comb
	begin
		if (rd_sel[0])
			sel_byte = in_p1;
		else if (rd_sel[1])
			sel_byte = in_p2;
		else if (rd_sel[2])
			sel_byte = p3_byte;
		else if (rd_sel[3])
			sel_byte = p4_byte;
		else
			sel_byte = '0;
	end

	// Registered at the end of the execute cycle
	// Byte is valid for the first acknowledge cycle, zero otherwise
	always_ff @(posedge clk)
	begin
		if (reset)
			io_rdata <= '0;
		else
			io_rdata <= sel_byte;
	end

endmodule

/* design/io_port_decode.sv */
// Port request decode
`timescale 1ns/1ps

module io_port_decode (
	input  logic                                clk,
	input  logic                                reset,
	input  vic_io_pkg::game_e                   game_mode,
	input  logic                                io_req,
	input  logic                                io_wr,
	input  logic [vic_io_pkg::PORT_W-1:0]       io_addr,
	input  logic [vic_io_pkg::PORT_W-1:0]       io_wdata,
	output logic                                io_ack,
	output logic [vic_io_pkg::NUM_PORTS-1:0]    rd_sel,
	output logic                                p4_read,
	output logic [vic_io_pkg::NUM_PORTS-1:0]    wr_mask,
	output logic                                bank_hit,
	output logic [vic_io_pkg::PORT_W-1:0]       wdata
);
	import vic_io_pkg::*;

	io_state_e state;
	logic req_wr;
	logic [PORT_W-1:0] req_addr;
	logic [PORT_W-1:0] req_wdata;
	logic exec;
	logic alt_style;
	logic [NUM_PORTS-1:0] std_sel;
	logic [NUM_PORTS-1:0] alt_sel;

	// Handshake FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= IO_IDLE;
		else
		begin
			case (state)
				IO_IDLE: if (io_req) state <= IO_EXEC;
				// Single execute cycle, strobes live here
				IO_EXEC: state <= IO_ACK;
				// Held until the master drops its request
				IO_ACK: if (!io_req) state <= IO_IDLE;
				default: state <= IO_IDLE;
			endcase
		end
	end

	// Capture of the request as it is accepted
	always_ff @(posedge clk)
	begin
		if (state == IO_IDLE && io_req)
		begin
			req_wr    <= io_wr;
			req_addr  <= io_addr;
			req_wdata <= io_wdata;
		end
	end

	assign exec   = (state == IO_EXEC);
	assign io_ack = (state == IO_ACK);

	// Read select styles
	// ----------------------------------------
	// Alternate decode for Carnival and Pulsar
	always_comb
	begin
		case (game_mode)
			GAME_CARNIVAL, GAME_PULSAR: alt_style = 1'b1;
			default: alt_style = 1'b0;
		endcase
	end

	// Standard style, bit mask with P1 winning
	always_comb
	begin
		if (req_addr[0])
			std_sel = 4'b0001;
		else if (req_addr[1])
			std_sel = 4'b0010;
		else if (req_addr[2])
			std_sel = 4'b0100;
		else if (req_addr[3])
			std_sel = 4'b1000;
		else
			std_sel = 4'b0000;
	end

	// Alternate style, address bits 1:0 as index
	assign alt_sel = 4'b0001 << req_addr[1:0];

	// Strobes, one cycle only
	assign rd_sel   = (exec && !req_wr) ? (alt_style ? alt_sel : std_sel) : '0;
	assign p4_read  = rd_sel[NUM_PORTS-1];
	// Writes always use the mask, every set bit is a port
	assign wr_mask  = (exec && req_wr) ? req_addr[NUM_PORTS-1:0] : '0;
	assign bank_hit = exec && req_wr && req_addr[6];
	assign wdata    = req_wdata;

endmodule

/* design/output_ports.sv */
// Output latches and colour bank
`timescale 1ns/1ps

module output_ports (
	input  logic                             clk,
	input  logic                             reset,
	input  vic_io_pkg::game_e                game_mode,
	input  logic [vic_io_pkg::NUM_PORTS-1:0] wr_mask,
	input  logic                             bank_hit,
	input  logic [vic_io_pkg::PORT_W-1:0]    wdata,
	output logic [vic_io_pkg::PORT_W-1:0]    out_p1,
	output logic [vic_io_pkg::PORT_W-1:0]    out_p2,
	output logic [vic_io_pkg::PORT_W-1:0]    out_p3,
	output logic [vic_io_pkg::PORT_W-1:0]    out_p4,
	output logic [vic_io_pkg::BANK_W-1:0]    colour_bank
);
	import vic_io_pkg::*;

	logic bank_wr;

	// N-Sub switches bank on P2 writes only
	assign bank_wr = (game_mode == GAME_NSUB) ? wr_mask[1] : bank_hit;

	// Output latches
	// ----------------------------------------
	// Every masked port takes the same byte
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_p1      <= OUT_RESET;
			out_p2      <= OUT_RESET;
			out_p3      <= OUT_RESET;
			out_p4      <= OUT_RESET;
			colour_bank <= BANK_RESET;
		end
		else
		begin
			if (wr_mask[0]) out_p1 <= wdata;
			if (wr_mask[1]) out_p2 <= wdata;
			if (wr_mask[2]) out_p3 <= wdata;
			if (wr_mask[3]) out_p4 <= wdata;
			// Bank from the low data bits
			if (bank_wr) colour_bank <= wdata[BANK_W-1:0];
		end
	end

endmodule

/* design/vic_io_pkg.sv */
// VIC I/O shared definitions
package vic_io_pkg;

	// Game profiles
	// ----------------------------------------
	// Codes follow the board game select input
	typedef enum logic [4:0] {
		GAME_CARNIVAL    = 5'd3,
		GAME_NSUB        = 5'd12,
		GAME_PULSAR      = 5'd13,
		GAME_SPACEATTACK = 5'd16
	} game_e;

	// Port transaction states
	typedef enum logic [1:0] {
		IO_IDLE = 2'd0,
		IO_EXEC = 2'd1,
		IO_ACK  = 2'd2
	} io_state_e;

	// Port bus and latch widths
	// ----------------------------------------
	localparam int PORT_W    = 8;
	localparam int NUM_PORTS = 4;
	localparam int BANK_W    = 2;

	// Values seen after reset
	localparam logic [PORT_W-1:0] OUT_RESET  = 8'hFF;
	localparam logic [BANK_W-1:0] BANK_RESET = 2'b01;

	// Timer and coin circuit
	// ----------------------------------------
	localparam int TIMER_W = 16;
	// Timer bit toggles every TIMER_PERIOD+1 clocks
	localparam logic [TIMER_W-1:0] TIMER_PERIOD = 16'd19500;
	// Start counter, all ones gives a 63 clock CPU reset
	localparam int COIN_START_W = 6;
	// Latch counter, all ones is the long length
	localparam int COIN_LATCH_W = 10;
	localparam logic [COIN_LATCH_W-1:0] COIN_LATCH_SHORT = 10'd15;

endpackage

/* design/vic_io_top.sv */
// VIC I/O port section
`timescale 1ns/1ps

module vic_io_top (
	input  logic                          clk,
	input  logic                          reset,
	input  vic_io_pkg::game_e             game_mode,
	input  logic                          coin,
	input  logic [vic_io_pkg::PORT_W-1:0] in_p1,
	input  logic [vic_io_pkg::PORT_W-1:0] in_p2,
	input  logic [vic_io_pkg::PORT_W-1:0] in_p3,
	input  logic [vic_io_pkg::PORT_W-1:0] in_p4,
	input  logic                          io_req,
	input  logic                          io_wr,
	input  logic [vic_io_pkg::PORT_W-1:0] io_addr,
	input  logic [vic_io_pkg::PORT_W-1:0] io_wdata,
	output logic                          io_ack,
	output logic [vic_io_pkg::PORT_W-1:0] io_rdata,
	output logic [vic_io_pkg::PORT_W-1:0] out_p1,
	output logic [vic_io_pkg::PORT_W-1:0] out_p2,
	output logic [vic_io_pkg::PORT_W-1:0] out_p3,
	output logic [vic_io_pkg::PORT_W-1:0] out_p4,
	output logic [vic_io_pkg::BANK_W-1:0] colour_bank,
	output logic                          cpu_reset
);
	import vic_io_pkg::*;

	// Execute cycle strobes
	logic [NUM_PORTS-1:0] rd_sel;
	logic p4_read;
	logic [NUM_PORTS-1:0] wr_mask;
	logic bank_hit;
	logic [PORT_W-1:0] wdata;
	// Sense bits for the read overlay
	logic timer_bit;
	logic coin_active;

	io_port_decode u_decode (.clk(clk), .reset(reset), .game_mode(game_mode),
		.io_req(io_req), .io_wr(io_wr), .io_addr(io_addr), .io_wdata(io_wdata),
		.io_ack(io_ack), .rd_sel(rd_sel), .p4_read(p4_read), .wr_mask(wr_mask),
		.bank_hit(bank_hit), .wdata(wdata));

	coin_timer u_coin (.clk(clk), .reset(reset), .game_mode(game_mode),
		.coin(coin), .p4_read(p4_read), .timer_bit(timer_bit),
		.coin_active(coin_active), .cpu_reset(cpu_reset));

	input_ports u_inputs (.clk(clk), .reset(reset), .game_mode(game_mode),
		.in_p1(in_p1), .in_p2(in_p2), .in_p3(in_p3), .in_p4(in_p4),
		.rd_sel(rd_sel), .timer_bit(timer_bit), .coin_active(coin_active),
		.io_rdata(io_rdata));

	output_ports u_outputs (.clk(clk), .reset(reset), .game_mode(game_mode),
		.wr_mask(wr_mask), .bank_hit(bank_hit), .wdata(wdata),
		.out_p1(out_p1), .out_p2(out_p2), .out_p3(out_p3), .out_p4(out_p4),
		.colour_bank(colour_bank));

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_vic_io -o tb_vic_io -f vic_io.f \
	&& ./obj_dir/tb_vic_io | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run_sim: passed" && exit 0 \
	|| { echo "run_sim: failed"; exit 1; }

/* tests/tb_vic_io.sv */
// VIC I/O testbench
`timescale 1ns/1ps

module tb_vic_io;
	import vic_io_pkg::*;

	localparam int HALF_PERIOD  = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 5;
	localparam int ACK_LIMIT    = 16;

	logic clk = 1'b0;
	logic reset;
	game_e game_mode;
	logic coin;
	logic [7:0] in_p1, in_p2, in_p3, in_p4;
	logic io_req;
	logic io_wr;
	logic [7:0] io_addr;
	logic [7:0] io_wdata;
	logic io_ack;
	logic [7:0] io_rdata;
	logic [7:0] out_p1, out_p2, out_p3, out_p4;
	logic [1:0] colour_bank;
	logic cpu_reset;

	logic [31:0] rng_state;
	int watchdog_cycles = 0;
	int fd;
	int rc;
	int line_count;
	logic [8*16-1:0] cmd;
	logic [8*256-1:0] line_buf;
	logic [31:0] arg_a, arg_b, arg_c, arg_d, arg_e, arg_f;

	vic_io_top u_dut (.clk(clk), .reset(reset), .game_mode(game_mode), .coin(coin),
		.in_p1(in_p1), .in_p2(in_p2), .in_p3(in_p3), .in_p4(in_p4),
		.io_req(io_req), .io_wr(io_wr), .io_addr(io_addr), .io_wdata(io_wdata),
		.io_ack(io_ack), .io_rdata(io_rdata), .out_p1(out_p1), .out_p2(out_p2),
		.out_p3(out_p3), .out_p4(out_p4), .colour_bank(colour_bank),
		.cpu_reset(cpu_reset));

	// 20 ns clock
	always #HALF_PERIOD clk = ~clk;

	// Helpers
	// ----------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			fail_run("value mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Read model, port select then sense overlay
	function automatic logic [7:0] expected_read(input game_e game, input logic [7:0] addr,
		input logic [7:0] p1, input logic [7:0] p2, input logic [7:0] p3,
		input logic [7:0] p4, input logic timer, input logic coin_act);
		int port;
		logic alt;
		logic [7:0] data;
		alt = (game == GAME_CARNIVAL) || (game == GAME_PULSAR);
		port = -1;
		if (alt)
			port = int'(addr[1:0]);
		else if (addr[0])
			port = 0;
		else if (addr[1])
			port = 1;
		else if (addr[2])
			port = 2;
		else if (addr[3])
			port = 3;
		case (port)
			0: data = p1;
			1: data = p2;
			2: data = p3;
			3: data = p4;
			default: data = 8'h00;
		endcase
		// Timer on P3 bit 3 for the alternate-style games
		if (port == 2 && alt)
			data[3] = timer;
		if (port == 3)
		begin
			if (game == GAME_SPACEATTACK)
			begin
				data[0] = timer;
				data[7] = ~coin_act;
			end
			else if (alt)
				data[3] = coin_act;
			else if (game == GAME_NSUB)
				data[7] = ~coin_act;
		end
		return data;
	endfunction

	// Bus master
	// ----------------------------------------
	task automatic next_edge();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Waits for io_ack to reach a level, returns the edges spent
	task automatic await_ack(input logic level, output int waited);
		waited = 0;
		next_edge();
		while (io_ack !== level)
		begin
			waited = waited + 1;
			if (waited > ACK_LIMIT)
				fail_run(level ? "io_ack never rose" : "io_ack stuck high after io_req fell");
			next_edge();
		end
	endtask

	task automatic start_request(input logic wr, input logic [7:0] addr,
		input logic [7:0] data);
		int waited;
		io_req   = 1'b1;
		io_wr    = wr;
		io_addr  = addr;
		io_wdata = data;
		// Ack two edges after the request is first seen
		await_ack(1'b1, waited);
		compare_value("io_ack rise delay", waited, 1);
	endtask

	task automatic finish_request();
		int waited;
		io_req = 1'b0;
		io_wr  = 1'b0;
		await_ack(1'b0, waited);
		compare_value("io_ack fall delay", waited, 0);
	endtask

	task automatic port_write(input logic [7:0] addr, input logic [7:0] data);
		start_request(1'b1, addr, data);
		finish_request();
	endtask

	// Fresh random player inputs for every read
	task automatic port_read(input logic [7:0] addr, input logic timer,
		input logic coin_act, input int count);
		logic [7:0] expected;
		for (int i = 0; i < count; i++)
		begin
			rng_state = xorshift32(rng_state);
			in_p1 = rng_state[7:0];
			in_p2 = rng_state[15:8];
			in_p3 = rng_state[23:16];
			in_p4 = rng_state[31:24];
			expected = expected_read(game_mode, addr, in_p1, in_p2, in_p3, in_p4,
				timer, coin_act);
			start_request(1'b0, addr, 8'h00);
			compare_value("io_rdata", io_rdata, expected);
			finish_request();
		end
	endtask

	// Write then keep io_req up, data changed under it
	task automatic hold_write(input logic [7:0] addr, input logic [7:0] data,
		input int cycles);
		logic bank_sel;
		bank_sel = (game_mode == GAME_NSUB) ? addr[1] : addr[6];
		start_request(1'b1, addr, data);
		io_wdata = ~data;
		repeat (cycles)
		begin
			next_edge();
			compare_value("io_ack", io_ack, 1'b1);
			// Masked latches keep the accepted byte
			if (addr[0])
				compare_value("out_p1", out_p1, data);
			if (addr[1])
				compare_value("out_p2", out_p2, data);
			if (addr[2])
				compare_value("out_p3", out_p3, data);
			if (addr[3])
				compare_value("out_p4", out_p4, data);
			if (bank_sel)
				compare_value("colour_bank", colour_bank, data[1:0]);
		end
		finish_request();
	endtask

	task automatic pulse_coin();
		coin = 1'b1;
		next_edge();
		// Pulse starts at the first edge that sees the coin
		compare_value("cpu_reset", cpu_reset, 1'b1);
		repeat (4) next_edge();
		coin = 1'b0;
		next_edge();
	endtask

	task automatic apply_reset(input logic [4:0] game);
		reset     = 1'b1;
		game_mode = game_e'(game);
		io_req    = 1'b0;
		coin      = 1'b0;
		repeat (RESET_CYCLES) next_edge();
		compare_value("cpu_reset", cpu_reset, 1'b1);
		compare_value("io_ack", io_ack, 1'b0);
		compare_value("io_rdata", io_rdata, 8'h00);
		reset = 1'b0;
		next_edge();
	endtask

	task automatic check_outputs(input logic [7:0] p1, input logic [7:0] p2,
		input logic [7:0] p3, input logic [7:0] p4, input logic [1:0] bank,
		input logic rst);
		compare_value("out_p1", out_p1, p1);
		compare_value("out_p2", out_p2, p2);
		compare_value("out_p3", out_p3, p3);
		compare_value("out_p4", out_p4, p4);
		compare_value("colour_bank", colour_bank, bank);
		compare_value("cpu_reset", cpu_reset, rst);
	endtask

	// Stimulus file
	// ----------------------------------------
	task automatic need_args(input int got, input int wanted);
		if (got != wanted)
			fail_run("malformed line in the stimulus file");
	endtask

	task automatic run_command();
		if (cmd == "#")
			rc = $fgets(line_buf, fd);
		else if (cmd == "reset")
		begin
			rc = $fscanf(fd, "%h", arg_a);
			need_args(rc, 1);
			apply_reset(arg_a[4:0]);
		end
		else if (cmd == "write")
		begin
			rc = $fscanf(fd, "%h %h", arg_a, arg_b);
			need_args(rc, 2);
			port_write(arg_a[7:0], arg_b[7:0]);
		end
		else if (cmd == "read")
		begin
			rc = $fscanf(fd, "%h %h %h %d", arg_a, arg_b, arg_c, arg_d);
			need_args(rc, 4);
			port_read(arg_a[7:0], arg_b[0], arg_c[0], int'(arg_d));
		end
		else if (cmd == "coin")
			pulse_coin();
		else if (cmd == "wait")
		begin
			rc = $fscanf(fd, "%d", arg_a);
			need_args(rc, 1);
			repeat (arg_a) next_edge();
		end
		else if (cmd == "check")
		begin
			rc = $fscanf(fd, "%h %h %h %h %h %h", arg_a, arg_b, arg_c, arg_d, arg_e, arg_f);
			need_args(rc, 6);
			check_outputs(arg_a[7:0], arg_b[7:0], arg_c[7:0], arg_d[7:0], arg_e[1:0],
				arg_f[0]);
		end
		else if (cmd == "hold")
		begin
			rc = $fscanf(fd, "%h %h %d", arg_a, arg_b, arg_c);
			need_args(rc, 3);
			hold_write(arg_a[7:0], arg_b[7:0], int'(arg_c));
		end
		else
			fail_run("unknown command in the stimulus file");
	endtask

	// Main sequence
	initial
	begin
		reset       = 1'b1;
		game_mode   = GAME_SPACEATTACK;
		coin        = 1'b0;
		in_p1       = 8'h00;
		in_p2       = 8'h00;
		in_p3       = 8'h00;
		in_p4       = 8'h00;
		io_req      = 1'b0;
		io_wr       = 1'b0;
		io_addr     = 8'h00;
		io_wdata    = 8'h00;
		rng_state   = 32'h18e89555;
		fd = $fopen("tests/vic_io_stim.txt", "r");
		if (fd == 0)
			fail_run("cannot open tests/vic_io_stim.txt");
		// Line count sizes the watchdog
		line_count = 0;
		while (!$feof(fd))
		begin
			rc = $fgets(line_buf, fd);
			if (rc > 0)
				line_count = line_count + 1;
		end
		$fclose(fd);
		watchdog_cycles = line_count * 2000 + 60000;
		fd = $fopen("tests/vic_io_stim.txt", "r");
		next_edge();
		while (!$feof(fd))
		begin
			rc = $fscanf(fd, "%s", cmd);
			if (rc == 1)
				run_command();
		end
		$fclose(fd);
		$display("SIMULATION PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		fail_run("timeout: the test sequence did not finish in time");
	end

endmodule

/* tests/vic_io_stim.txt */
# Columns: command then arguments, hex except wait and count in decimal
# reset game | write addr data | read addr timer coin_active count | coin | wait n
# check p1 p2 p3 p4 bank cpu_reset | hold addr data n
reset 10
check ff ff ff ff 1 0
write 05 a5
check a5 ff a5 ff 1 0
write 0a 3c
check a5 3c a5 3c 1 0
read 01 1 0 1
read 06 1 0 2
read 0c 1 0 1
read 08 1 0 2
read 00 1 0 1
wait 25000
read 08 0 0 1
coin
wait 100
check a5 3c a5 3c 1 0
read 08 0 0 1
read 08 0 1 17
reset 03
read 05 1 0 1
read 02 1 0 1
write 40 02
check ff ff ff ff 2 0
write 02 03
check ff 03 ff ff 2 0
reset 0d
coin
wait 100
check ff ff ff ff 1 0
read 03 1 0 1
read 03 1 1 15
read 03 1 0 1
read 01 1 0 1
reset 0c
write 40 03
check ff ff ff ff 1 0
write 02 02
check ff 02 ff ff 2 0
hold 0f 77 10
check 77 77 77 77 3 0
read 08 1 0 1

/* vic_io.f */
design/vic_io_pkg.sv
design/io_port_decode.sv
design/coin_timer.sv
design/input_ports.sv
design/output_ports.sv
design/vic_io_top.sv
tests/tb_vic_io.sv
